//--- hw/ring_pkg.sv
package ring_pkg;

	// Every node on the ring has a small numeric address
	localparam int unsigned NODE_ID_W = 4;

	// The opcode field is two bits wide on every ring packet
	localparam int unsigned OP_W = 2;

	// Packet kinds that travel on the ring
	typedef enum logic [OP_W-1:0] {
		OP_NOP        = 2'd0, // Empty slot, consumed without effect
		OP_WRITE      = 2'd1, // Remote byte-enabled write into the target node's RAM
		OP_READ       = 2'd2, // Remote word read, answered with a reply packet
		OP_READ_REPLY = 2'd3  // Data coming back to the node that asked
	} ring_op_e;

	// True for the packet kinds that end up as a RAM access at the target
	function automatic logic is_mem_req(input ring_op_e op);
		logic hit;
		hit = (op == OP_WRITE) || (op == OP_READ);
		return hit;
	endfunction

	// Read replies carry no address, so the field is zero on the wire
	// and all byte lanes are marked valid

endpackage

//--- hw/mem_pkg.sv
package mem_pkg;

	localparam int unsigned DATA_W = 32;          // Width of one RAM word
	localparam int unsigned BYTE_W = 8;           // Width of one byte lane
	localparam int unsigned SEL_W  = DATA_W / BYTE_W; // One enable bit per lane

	// Last side that won the RAM port
	// ARB_IDLE only exists between reset and the first grant
	typedef enum logic [1:0] {
		ARB_IDLE   = 2'd0,
		ARB_REMOTE = 2'd1, // Request popped from the remote queue
		ARB_HOST   = 2'd2  // Request taken from the local host port
	} arb_state_e;

endpackage

//--- hw/req_fifo.sv
`timescale 1ns/1ps

module req_fifo
	import ring_pkg::*;
	import mem_pkg::*;
#(
	parameter int unsigned RAM_AW     = 10, // Word address width
	parameter int unsigned FIFO_DEPTH = 4   // Number of queued requests
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	// Write side
	input  logic                 wvalid_i,
	output logic                 wready_o,
	input  ring_op_e             op_i,
	input  logic [NODE_ID_W-1:0] src_i,
	input  logic [RAM_AW-1:0]    adr_i,
	input  logic [SEL_W-1:0]     sel_i,
	input  logic [DATA_W-1:0]    dat_i,
	// Read side
	output logic                 rvalid_o,
	input  logic                 rready_i,
	output ring_op_e             op_o,
	output logic [NODE_ID_W-1:0] src_o,
	output logic [RAM_AW-1:0]    adr_o,
	output logic [SEL_W-1:0]     sel_o,
	output logic [DATA_W-1:0]    dat_o
);

	localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

	ring_op_e             op_mem  [FIFO_DEPTH];
	logic [NODE_ID_W-1:0] src_mem [FIFO_DEPTH];
	logic [RAM_AW-1:0]    adr_mem [FIFO_DEPTH];
	logic [SEL_W-1:0]     sel_mem [FIFO_DEPTH];
	logic [DATA_W-1:0]    dat_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
	logic [CNT_W-1:0] cnt_q;
	logic             push, pop;

	assign wready_o = (cnt_q != CNT_W'(FIFO_DEPTH)); // Not full
	assign rvalid_o = (cnt_q != '0);                 // Not empty
	assign push     = wvalid_i && wready_o;
	assign pop      = rvalid_o && rready_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			// Pointers wrap by compare so any depth works
			if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q; // Both or neither leave the fill level alone
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			op_mem[wr_ptr_q]  <= op_i;
			src_mem[wr_ptr_q] <= src_i;
			adr_mem[wr_ptr_q] <= adr_i;
			sel_mem[wr_ptr_q] <= sel_i;
			dat_mem[wr_ptr_q] <= dat_i;
		end
	end

	// Head of the queue is read straight out of the array
	assign op_o  = op_mem[rd_ptr_q];
	assign src_o = src_mem[rd_ptr_q];
	assign adr_o = adr_mem[rd_ptr_q];
	assign sel_o = sel_mem[rd_ptr_q];
	assign dat_o = dat_mem[rd_ptr_q];

endmodule

//--- hw/node_ram.sv
`timescale 1ns/1ps

module node_ram
	import mem_pkg::*;
#(
	parameter int unsigned RAM_AW = 10 // Word address width
) (
	input  logic              clk_i,
	input  logic              en_i,
	input  logic [SEL_W-1:0]  we_i,   // One write enable per byte lane
	input  logic [RAM_AW-1:0] adr_i,
	input  logic [DATA_W-1:0] wdat_i,
	output logic [DATA_W-1:0] rdat_o
);

	localparam int unsigned WORDS = 2 ** RAM_AW;

	logic [DATA_W-1:0] mem [WORDS];

	// Byte lanes are written independently
	always_ff @(posedge clk_i) begin
		if (en_i) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (we_i[i]) begin
					mem[adr_i][i*BYTE_W +: BYTE_W] <= wdat_i[i*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// Registered read returns the word as it was before a same-cycle write
	always_ff @(posedge clk_i) begin
		if (en_i) begin
			rdat_o <= mem[adr_i];
		end
	end

endmodule

//--- hw/node_arbiter.sv
`timescale 1ns/1ps

module node_arbiter
	import ring_pkg::*;
	import mem_pkg::*;
#(
	parameter int unsigned RAM_AW = 10 // Word address width
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	// Head of the remote request queue
	input  logic                 q_rvalid_i,
	output logic                 q_rready_o,
	input  ring_op_e             q_op_i,
	input  logic [NODE_ID_W-1:0] q_src_i,
	input  logic [RAM_AW-1:0]    q_adr_i,
	input  logic [SEL_W-1:0]     q_sel_i,
	input  logic [DATA_W-1:0]    q_dat_i,
	// Local host port
	input  logic                 host_valid_i,
	output logic                 host_ready_o,
	input  logic                 host_we_i,
	input  logic [RAM_AW-1:0]    host_adr_i,
	input  logic [SEL_W-1:0]     host_sel_i,
	input  logic [DATA_W-1:0]    host_dat_i,
	output logic                 host_rvalid_o,
	output logic [DATA_W-1:0]    host_rdat_o,
	// Reply path to the NIC
	input  logic                 rep_free_i,
	output logic                 rep_valid_o,
	output logic [NODE_ID_W-1:0] rep_dst_o,
	output logic [DATA_W-1:0]    rep_dat_o,
	// RAM port
	output logic                 ram_en_o,
	output logic [SEL_W-1:0]     ram_we_o,
	output logic [RAM_AW-1:0]    ram_adr_o,
	output logic [DATA_W-1:0]    ram_wdat_o,
	input  logic [DATA_W-1:0]    ram_rdat_i
);

	arb_state_e           last_q;     // Side that got the port most recently
	logic                 live_q;
	logic                 remote_req; // Queue head can be served this cycle
	logic                 grant_host;
	logic                 grant_rem;
	logic                 rd_host_q;  // Host read issued on the previous edge
	logic                 rd_rem_q;   // Remote read issued on the previous edge
	logic [NODE_ID_W-1:0] rd_src_q;   // Requester of that remote read

	// ========================================
	// Grant logic
	// ========================================
	// A remote read also waits while its predecessor's reply is still on the way
	assign remote_req = live_q && q_rvalid_i &&
		(q_op_i != OP_READ || (rep_free_i && !rd_rem_q));

	// Host yields only when the queue is waiting and won less recently
	assign host_ready_o = live_q && !(remote_req && last_q != ARB_REMOTE);
	assign grant_host   = host_valid_i && host_ready_o;
	assign grant_rem    = remote_req && !grant_host;
	assign q_rready_o   = grant_rem;

	// The access goes to RAM in the same cycle as the handshake
	assign ram_en_o   = grant_host || grant_rem;
	assign ram_we_o   = grant_host ? (host_we_i ? host_sel_i : '0) :
		((grant_rem && q_op_i == OP_WRITE) ? q_sel_i : '0);
	assign ram_adr_o  = grant_host ? host_adr_i : q_adr_i;
	assign ram_wdat_o = grant_host ? host_dat_i : q_dat_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			live_q    <= 1'b0;
			last_q    <= ARB_IDLE;
			rd_host_q <= 1'b0;
			rd_rem_q  <= 1'b0;
		end else begin
			live_q <= 1'b1;
			if (grant_host) begin
				last_q <= ARB_HOST;
			end else if (grant_rem) begin
				last_q <= ARB_REMOTE;
			end
			rd_host_q <= grant_host && !host_we_i;
			rd_rem_q  <= grant_rem && (q_op_i == OP_READ);
		end
	end

	always_ff @(posedge clk_i) begin
		if (grant_rem) rd_src_q <= q_src_i; // Reply goes back to whoever asked
	end

	// ========================================
	// Read return steering
	// ========================================
	assign host_rvalid_o = rd_host_q;
	assign host_rdat_o   = ram_rdat_i;
	assign rep_valid_o   = rd_rem_q;
	assign rep_dst_o     = rd_src_q;
	assign rep_dat_o     = ram_rdat_i;

endmodule

//--- hw/ring_nic.sv
`timescale 1ns/1ps

module ring_nic
	import ring_pkg::*;
	import mem_pkg::*;
#(
	parameter logic [NODE_ID_W-1:0] NODE_ID = '0, // Ring address of this node
	parameter int unsigned          RAM_AW  = 10  // Word address width
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	// Ring input
	input  logic                 ring_in_valid_i,
	output logic                 ring_in_ready_o,
	input  logic [NODE_ID_W-1:0] ring_in_dst_i,
	input  logic [NODE_ID_W-1:0] ring_in_src_i,
	input  ring_op_e             ring_in_op_i,
	input  logic [RAM_AW-1:0]    ring_in_adr_i,
	input  logic [SEL_W-1:0]     ring_in_sel_i,
	input  logic [DATA_W-1:0]    ring_in_dat_i,
	// Ring output
	output logic                 ring_out_valid_o,
	input  logic                 ring_out_ready_i,
	output logic [NODE_ID_W-1:0] ring_out_dst_o,
	output logic [NODE_ID_W-1:0] ring_out_src_o,
	output ring_op_e             ring_out_op_o,
	output logic [RAM_AW-1:0]    ring_out_adr_o,
	output logic [SEL_W-1:0]     ring_out_sel_o,
	output logic [DATA_W-1:0]    ring_out_dat_o,
	// Push side of the request queue
	output logic                 q_wvalid_o,
	input  logic                 q_wready_i,
	output ring_op_e             q_op_o,
	output logic [NODE_ID_W-1:0] q_src_o,
	output logic [RAM_AW-1:0]    q_adr_o,
	output logic [SEL_W-1:0]     q_sel_o,
	output logic [DATA_W-1:0]    q_dat_o,
	// Read results coming back from the arbiter
	input  logic                 rep_valid_i,
	input  logic [NODE_ID_W-1:0] rep_dst_i,
	input  logic [DATA_W-1:0]    rep_dat_i,
	output logic                 rep_free_o
);

	logic                 live_q;     // Low during reset and for the first edge after it
	logic                 for_me;     // Incoming packet is addressed to this node
	logic                 is_req;     // Incoming packet needs a RAM access
	logic                 accept_ok;  // Nothing blocks the input in general
	logic                 stage_free; // Output register can take a new packet this cycle
	logic                 fwd_fire;   // A foreign packet moves into the output register
	logic                 rep_take;   // The pending reply moves into the output register

	logic                 rep_full_q;
	logic [NODE_ID_W-1:0] rep_dst_q;
	logic [DATA_W-1:0]    rep_dat_q;

	logic                 out_valid_q;
	logic [NODE_ID_W-1:0] out_dst_q;
	logic [NODE_ID_W-1:0] out_src_q;
	ring_op_e             out_op_q;
	logic [RAM_AW-1:0]    out_adr_q;
	logic [SEL_W-1:0]     out_sel_q;
	logic [DATA_W-1:0]    out_dat_q;

	// ========================================
	// Input decode and handshakes
	// ========================================
	assign for_me     = (ring_in_dst_i == NODE_ID);
	assign is_req     = is_mem_req(ring_in_op_i);
	assign accept_ok  = live_q && !rep_full_q; // A waiting reply freezes the whole input
	assign stage_free = !out_valid_q || ring_out_ready_i;

	// Local NOPs and stray replies are always swallowed, requests need queue room
	assign ring_in_ready_o = accept_ok && (for_me ? (!is_req || q_wready_i) : stage_free);

	assign q_wvalid_o = ring_in_valid_i && accept_ok && for_me && is_req;
	assign q_op_o     = ring_in_op_i;
	assign q_src_o    = ring_in_src_i; // Kept so that a read can be answered
	assign q_adr_o    = ring_in_adr_i;
	assign q_sel_o    = ring_in_sel_i;
	assign q_dat_o    = ring_in_dat_i;

	assign fwd_fire   = ring_in_valid_i && ring_in_ready_o && !for_me;
	assign rep_take   = rep_full_q && stage_free; // Replies win over forwarding
	assign rep_free_o = !rep_full_q;

	// ========================================
	// Control state
	// ========================================
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			live_q      <= 1'b0;
			rep_full_q  <= 1'b0;
			out_valid_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
			// The arbiter only starts a remote read while the slot is empty
			if (rep_valid_i) begin
				rep_full_q <= 1'b1;
			end else if (rep_take) begin
				rep_full_q <= 1'b0;
			end
			if (stage_free) begin
				out_valid_q <= rep_full_q || fwd_fire; // Drains to empty if nothing is waiting
			end
		end
	end

	// Reply slot and output register payload
	always_ff @(posedge clk_i) begin
		if (rep_valid_i) begin
			rep_dst_q <= rep_dst_i;
			rep_dat_q <= rep_dat_i;
		end
		if (rep_take) begin
			out_dst_q <= rep_dst_q;     // Back to the node that asked
			out_src_q <= NODE_ID;
			out_op_q  <= OP_READ_REPLY;
			out_adr_q <= '0;
			out_sel_q <= '1;
			out_dat_q <= rep_dat_q;
		end else if (fwd_fire) begin
			out_dst_q <= ring_in_dst_i; // Foreign packets pass through untouched
			out_src_q <= ring_in_src_i;
			out_op_q  <= ring_in_op_i;
			out_adr_q <= ring_in_adr_i;
			out_sel_q <= ring_in_sel_i;
			out_dat_q <= ring_in_dat_i;
		end
	end

	assign ring_out_valid_o = out_valid_q;
	assign ring_out_dst_o   = out_dst_q;
	assign ring_out_src_o   = out_src_q;
	assign ring_out_op_o    = out_op_q;
	assign ring_out_adr_o   = out_adr_q;
	assign ring_out_sel_o   = out_sel_q;
	assign ring_out_dat_o   = out_dat_q;

endmodule

//--- hw/ring_node.sv
`timescale 1ns/1ps

module ring_node
	import ring_pkg::*;
	import mem_pkg::*;
#(
	parameter logic [NODE_ID_W-1:0] NODE_ID    = '0, // Ring address of this node
	parameter int unsigned          RAM_AW     = 10, // Word address width of local RAM
	parameter int unsigned          FIFO_DEPTH = 4   // Remote requests that can wait
) (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 ring_in_valid_i,
	output logic                 ring_in_ready_o,
	input  logic [NODE_ID_W-1:0] ring_in_dst_i,
	input  logic [NODE_ID_W-1:0] ring_in_src_i,
	input  ring_op_e             ring_in_op_i,
	input  logic [RAM_AW-1:0]    ring_in_adr_i,
	input  logic [SEL_W-1:0]     ring_in_sel_i,
	input  logic [DATA_W-1:0]    ring_in_dat_i,
	output logic                 ring_out_valid_o,
	input  logic                 ring_out_ready_i,
	output logic [NODE_ID_W-1:0] ring_out_dst_o,
	output logic [NODE_ID_W-1:0] ring_out_src_o,
	output ring_op_e             ring_out_op_o,
	output logic [RAM_AW-1:0]    ring_out_adr_o,
	output logic [SEL_W-1:0]     ring_out_sel_o,
	output logic [DATA_W-1:0]    ring_out_dat_o,
	input  logic                 host_valid_i,
	output logic                 host_ready_o,
	input  logic                 host_we_i,
	input  logic [RAM_AW-1:0]    host_adr_i,
	input  logic [SEL_W-1:0]     host_sel_i,
	input  logic [DATA_W-1:0]    host_dat_i,
	output logic                 host_rvalid_o,
	output logic [DATA_W-1:0]    host_rdat_o
);

	// NIC to queue
	logic                 q_wvalid, q_wready;
	ring_op_e             q_w_op;
	logic [NODE_ID_W-1:0] q_w_src;
	logic [RAM_AW-1:0]    q_w_adr;
	logic [SEL_W-1:0]     q_w_sel;
	logic [DATA_W-1:0]    q_w_dat;
	// Queue to arbiter
	logic                 q_rvalid, q_rready;
	ring_op_e             q_r_op;
	logic [NODE_ID_W-1:0] q_r_src;
	logic [RAM_AW-1:0]    q_r_adr;
	logic [SEL_W-1:0]     q_r_sel;
	logic [DATA_W-1:0]    q_r_dat;
	// Arbiter to NIC reply path
	logic                 rep_valid, rep_free;
	logic [NODE_ID_W-1:0] rep_dst;
	logic [DATA_W-1:0]    rep_dat;
	// Arbiter to RAM
	logic                 ram_en;
	logic [SEL_W-1:0]     ram_we;
	logic [RAM_AW-1:0]    ram_adr;
	logic [DATA_W-1:0]    ram_wdat, ram_rdat;

	ring_nic #(.NODE_ID(NODE_ID), .RAM_AW(RAM_AW)) nic_i (
		.clk_i, .rst_n_i,
		.ring_in_valid_i, .ring_in_ready_o, .ring_in_dst_i, .ring_in_src_i,
		.ring_in_op_i, .ring_in_adr_i, .ring_in_sel_i, .ring_in_dat_i,
		.ring_out_valid_o, .ring_out_ready_i, .ring_out_dst_o, .ring_out_src_o,
		.ring_out_op_o, .ring_out_adr_o, .ring_out_sel_o, .ring_out_dat_o,
		.q_wvalid_o(q_wvalid), .q_wready_i(q_wready), .q_op_o(q_w_op), .q_src_o(q_w_src),
		.q_adr_o(q_w_adr), .q_sel_o(q_w_sel), .q_dat_o(q_w_dat),
		.rep_valid_i(rep_valid), .rep_dst_i(rep_dst), .rep_dat_i(rep_dat),
		.rep_free_o(rep_free)
	);

	req_fifo #(.RAM_AW(RAM_AW), .FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
		.clk_i, .rst_n_i,
		.wvalid_i(q_wvalid), .wready_o(q_wready), .op_i(q_w_op), .src_i(q_w_src),
		.adr_i(q_w_adr), .sel_i(q_w_sel), .dat_i(q_w_dat),
		.rvalid_o(q_rvalid), .rready_i(q_rready), .op_o(q_r_op), .src_o(q_r_src),
		.adr_o(q_r_adr), .sel_o(q_r_sel), .dat_o(q_r_dat)
	);

	node_arbiter #(.RAM_AW(RAM_AW)) arb_i (
		.clk_i, .rst_n_i,
		.q_rvalid_i(q_rvalid), .q_rready_o(q_rready), .q_op_i(q_r_op), .q_src_i(q_r_src),
		.q_adr_i(q_r_adr), .q_sel_i(q_r_sel), .q_dat_i(q_r_dat),
		.host_valid_i, .host_ready_o, .host_we_i, .host_adr_i, .host_sel_i, .host_dat_i,
		.host_rvalid_o, .host_rdat_o,
		.rep_free_i(rep_free), .rep_valid_o(rep_valid), .rep_dst_o(rep_dst),
		.rep_dat_o(rep_dat),
		.ram_en_o(ram_en), .ram_we_o(ram_we), .ram_adr_o(ram_adr), .ram_wdat_o(ram_wdat),
		.ram_rdat_i(ram_rdat)
	);

	node_ram #(.RAM_AW(RAM_AW)) ram_i (
		.clk_i,
		.en_i(ram_en), .we_i(ram_we), .adr_i(ram_adr), .wdat_i(ram_wdat), .rdat_o(ram_rdat)
	);

endmodule

//--- tb/ring_node_sva.sv
`timescale 1ns/1ps

module ring_node_sva
	import ring_pkg::*;
	import mem_pkg::*;
#(
	parameter int unsigned RAM_AW = 10 // Must follow the bound node
) (
	input logic                 clk_i,
	input logic                 rst_n_i,
	input logic                 ring_in_valid_i,
	input logic                 ring_in_ready_o,
	input logic                 ring_out_valid_o,
	input logic                 ring_out_ready_i,
	input logic [NODE_ID_W-1:0] ring_out_dst_o,
	input logic [NODE_ID_W-1:0] ring_out_src_o,
	input ring_op_e             ring_out_op_o,
	input logic [RAM_AW-1:0]    ring_out_adr_o,
	input logic [SEL_W-1:0]     ring_out_sel_o,
	input logic [DATA_W-1:0]    ring_out_dat_o,
	input logic                 host_valid_i,
	input logic                 host_ready_o,
	input logic                 host_we_i,
	input logic                 host_rvalid_o
);

	logic accepted_q; // Ring input has taken at least one packet since reset

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) accepted_q <= 1'b0;
		else if (ring_in_valid_i && ring_in_ready_o) accepted_q <= 1'b1;
	end

	// ========================================
	// Reset behavior
	// ========================================
	a_quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |->
		!ring_in_ready_o && !ring_out_valid_o && !host_ready_o && !host_rvalid_o)
		else $error("Handshake outputs active while reset is applied");

	// The first edge after release still sees every port closed
	a_quiet_after_release: assert property (@(posedge clk_i) $rose(rst_n_i) |->
		!ring_in_ready_o && !ring_out_valid_o && !host_ready_o && !host_rvalid_o)
		else $error("Handshake outputs active on the first edge after reset");

	a_no_output_before_input: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!accepted_q |-> !ring_out_valid_o)
		else $error("Ring output valid before any packet was accepted");

	// ========================================
	// Handshake rules
	// ========================================
	a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ring_out_valid_o && !ring_out_ready_i |=> ring_out_valid_o && $stable({ring_out_dst_o,
		ring_out_src_o, ring_out_op_o, ring_out_adr_o, ring_out_sel_o, ring_out_dat_o}))
		else $error("Ring output changed while stalled");

	a_host_read_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		host_valid_i && host_ready_o && !host_we_i |=> host_rvalid_o)
		else $error("Host read data missing one cycle after the handshake");

	a_host_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		host_rvalid_o |-> $past(host_valid_i && host_ready_o && !host_we_i))
		else $error("Host read data without a read handshake");

	a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!$isunknown({ring_in_ready_o, ring_out_valid_o, host_ready_o, host_rvalid_o}))
		else $error("Handshake output unknown");

endmodule

bind ring_node ring_node_sva #(.RAM_AW(RAM_AW)) sva_i (.*);

//--- tb/tb_ring_node.sv
`timescale 1ns/1ps

module tb_ring_node
	import ring_pkg::*;
	import mem_pkg::*;
();

	localparam logic [NODE_ID_W-1:0] MY_ID = 4'd5;
	localparam int unsigned RAM_AW = 10;
	localparam int unsigned LIMIT  = 500; // Cycles that any single wait may take
	localparam int unsigned PKT_W  = 2 * NODE_ID_W + OP_W + RAM_AW + SEL_W + DATA_W;
	localparam int unsigned REP_W  = 2 * NODE_ID_W + OP_W + DATA_W;
	localparam time         DRV    = 2ns;  // Inputs change this long after the rising edge

	logic clk, rst_n;
	logic ring_in_valid, ring_in_ready, ring_out_valid, ring_out_ready;
	logic [NODE_ID_W-1:0] ring_in_dst, ring_in_src, ring_out_dst, ring_out_src;
	ring_op_e ring_in_op, ring_out_op;
	logic [RAM_AW-1:0] ring_in_adr, ring_out_adr, host_adr;
	logic [SEL_W-1:0] ring_in_sel, ring_out_sel, host_sel;
	logic [DATA_W-1:0] ring_in_dat, ring_out_dat, host_dat, host_rdat;
	logic host_valid, host_ready, host_we, host_rvalid;

	logic [DATA_W-1:0] mem_model [2**RAM_AW]; // Word image of what the RAM should hold
	logic [PKT_W-1:0]  fwd_q [$];             // Foreign packets in arrival order
	logic [REP_W-1:0]  rep_q [$];             // Replies as {dst, src, op, dat}
	logic [DATA_W-1:0] host_q [$];
	logic [PKT_W-1:0]  fwd_exp;
	logic [REP_W-1:0]  rep_exp;
	logic [DATA_W-1:0] host_exp;
	logic              rd_due; // A host read handshake was seen one cycle ago
	int unsigned       errors, tests_run, tests_passed;

	ring_node #(.NODE_ID(MY_ID), .RAM_AW(RAM_AW), .FIFO_DEPTH(4)) dut_i (
		.clk_i(clk), .rst_n_i(rst_n),
		.ring_in_valid_i(ring_in_valid), .ring_in_ready_o(ring_in_ready),
		.ring_in_dst_i(ring_in_dst), .ring_in_src_i(ring_in_src), .ring_in_op_i(ring_in_op),
		.ring_in_adr_i(ring_in_adr), .ring_in_sel_i(ring_in_sel), .ring_in_dat_i(ring_in_dat),
		.ring_out_valid_o(ring_out_valid), .ring_out_ready_i(ring_out_ready),
		.ring_out_dst_o(ring_out_dst), .ring_out_src_o(ring_out_src),
		.ring_out_op_o(ring_out_op), .ring_out_adr_o(ring_out_adr),
		.ring_out_sel_o(ring_out_sel), .ring_out_dat_o(ring_out_dat),
		.host_valid_i(host_valid), .host_ready_o(host_ready), .host_we_i(host_we),
		.host_adr_i(host_adr), .host_sel_i(host_sel), .host_dat_i(host_dat),
		.host_rvalid_o(host_rvalid), .host_rdat_o(host_rdat)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] res;
		res = old_w;
		for (int i = 0; i < SEL_W; i++) begin
			if (sel[i]) res[i*8 +: 8] = new_w[i*8 +: 8]; // Lane i takes the new byte
		end
		return res;
	endfunction

	function automatic logic [NODE_ID_W-1:0] other_node();
		logic [NODE_ID_W-1:0] id;
		id = NODE_ID_W'($urandom_range(0, 14));
		if (id >= MY_ID) id = id + 1'b1; // Skips this node's own address
		return id;
	endfunction

	task automatic timeout_abort(input string what);
		$display("Timeout after %0d cycles while waiting for %s", LIMIT, what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic send_packet(input logic [NODE_ID_W-1:0] dst, input logic [NODE_ID_W-1:0] src,
		input ring_op_e op, input logic [RAM_AW-1:0] adr, input logic [SEL_W-1:0] sel,
		input logic [DATA_W-1:0] dat);
		int unsigned n;
		logic fire;
		if (dst != MY_ID) fwd_q.push_back({dst, src, op, adr, sel, dat});
		else if (op == OP_WRITE) mem_model[adr] = merge_bytes(mem_model[adr], dat, sel);
		else if (op == OP_READ) rep_q.push_back({src, MY_ID, OP_READ_REPLY, mem_model[adr]});
		ring_in_valid = 1'b1;
		ring_in_dst   = dst;
		ring_in_src   = src;
		ring_in_op    = op;
		ring_in_adr   = adr;
		ring_in_sel   = sel;
		ring_in_dat   = dat;
		n    = 0;
		fire = 1'b0;
		while (!fire) begin
			@(negedge clk);
			fire = ring_in_ready; // Transfer happens on the coming edge
			@(posedge clk);
			#DRV;
			n++;
			if (n > LIMIT) timeout_abort("ring input ready");
		end
		ring_in_valid = 1'b0;
	endtask

	task automatic send_foreign();
		send_packet(other_node(), other_node(), ring_op_e'($urandom_range(0, 3)),
			RAM_AW'($urandom), SEL_W'($urandom), $urandom);
	endtask

	task automatic host_access(input logic we, input logic [RAM_AW-1:0] adr,
		input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat);
		int unsigned n;
		logic fire;
		if (we) mem_model[adr] = merge_bytes(mem_model[adr], dat, sel);
		else host_q.push_back(mem_model[adr]);
		host_valid = 1'b1;
		host_we    = we;
		host_adr   = adr;
		host_sel   = sel;
		host_dat   = dat;
		n    = 0;
		fire = 1'b0;
		while (!fire) begin
			@(negedge clk);
			fire = host_ready;
			@(posedge clk);
			#DRV;
			n++;
			if (n > LIMIT) timeout_abort("host port ready");
		end
		host_valid = 1'b0;
	endtask

	task automatic wait_quiet(input string what);
		int unsigned n;
		n = 0;
		while (fwd_q.size() != 0 || rep_q.size() != 0 || host_q.size() != 0) begin
			@(posedge clk);
			#DRV;
			n++;
			if (n > LIMIT) timeout_abort(what);
		end
	endtask

	task automatic finish_test(input string name, input int unsigned err_start);
		int unsigned found;
		found = errors - err_start;
		tests_run++;
		if (found == 0) tests_passed++;
		$display("[%0t] %s: %s, %0d errors", $time, name, (found == 0) ? "passed" : "failed", found);
	endtask

	// ========================================
	// Output scoreboard
	// ========================================
	always @(negedge clk) begin
		if (rst_n && ring_out_valid && ring_out_ready) begin
			if (ring_out_src == MY_ID && ring_out_op == OP_READ_REPLY) begin
				if (rep_q.size() == 0) begin
					$display("Read reply at %0t arrived with no remote read outstanding", $time);
					errors++;
				end else begin
					rep_exp = rep_q.pop_front();
					assert ({ring_out_dst, ring_out_src, ring_out_op, ring_out_dat} === rep_exp)
					else begin
						$display("MISMATCH at %0t: reply dst %0d data %h, expected dst %0d data %h",
							$time, ring_out_dst, ring_out_dat, rep_exp[REP_W-1 -: NODE_ID_W],
							rep_exp[DATA_W-1:0]);
						errors++;
					end
				end
			end else if (fwd_q.size() == 0) begin
				$display("Packet at %0t left the ring output but none was expected", $time);
				errors++;
			end else begin
				fwd_exp = fwd_q.pop_front();
				assert ({ring_out_dst, ring_out_src, ring_out_op, ring_out_adr, ring_out_sel,
					ring_out_dat} === fwd_exp)
				else begin
					$display("MISMATCH at %0t: forwarded packet %h, expected %h", $time,
						{ring_out_dst, ring_out_src, ring_out_op, ring_out_adr, ring_out_sel,
						ring_out_dat}, fwd_exp);
					errors++;
				end
			end
		end
	end

	// Host read data must follow its handshake by exactly one cycle
	always @(negedge clk) begin
		if (rst_n) begin
			assert (host_rvalid === rd_due) else begin
				$display("MISMATCH at %0t: host_rvalid_o is %b, expected %b", $time,
					host_rvalid, rd_due);
				errors++;
			end
			if (host_rvalid && host_q.size() != 0) begin
				host_exp = host_q.pop_front();
				assert (host_rdat === host_exp) else begin
					$display("MISMATCH at %0t: host read data %h, expected %h", $time,
						host_rdat, host_exp);
					errors++;
				end
			end
			rd_due = host_valid && host_ready && !host_we;
		end else begin
			rd_due = 1'b0;
		end
	end

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		int unsigned mark;
		int unsigned stretch;
		logic [RAM_AW-1:0] a;
		void'($urandom(21));
		errors = 0;
		tests_run = 0;
		tests_passed = 0;
		rd_due = 1'b0;
		rst_n = 1'b1;
		ring_in_valid = 1'b0;
		ring_in_dst = '0;
		ring_in_src = '0;
		ring_in_op = OP_NOP;
		ring_in_adr = '0;
		ring_in_sel = '0;
		ring_in_dat = '0;
		ring_out_ready = 1'b0;
		host_valid = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_sel = '0;
		host_dat = '0;
		#1 rst_n = 1'b0; // A real falling edge for the asynchronous reset

		// Test 1, ports stay closed through reset and until traffic arrives
		mark = errors;
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (!ring_in_ready && !ring_out_valid && !host_ready && !host_rvalid) else begin
			$display("MISMATCH at %0t: handshake outputs active during reset", $time);
			errors++;
		end
		@(posedge clk);
		#DRV rst_n = 1'b1;
		ring_out_ready = 1'b1;
		repeat (4) begin
			@(negedge clk);
			assert (!ring_out_valid) else begin
				$display("MISMATCH at %0t: ring output valid with no input", $time);
				errors++;
			end
		end
		@(posedge clk);
		#DRV;
		finish_test("reset and idle", mark);

		// Test 2, foreign traffic passes through unchanged and in order
		mark = errors;
		repeat (8) send_foreign();
		wait_quiet("forwarded packets");
		finish_test("forwarding", mark);

		// Test 3, partial remote write merges with the old word
		mark = errors;
		a = 10'h123;
		host_access(1'b1, a, 4'hF, $urandom);
		send_packet(MY_ID, 4'd3, OP_WRITE, a, 4'b0101, $urandom);
		send_packet(MY_ID, 4'd3, OP_READ, a, 4'hF, '0); // Queue order puts it after the write
		wait_quiet("remote write then read");
		host_access(1'b0, a, '0, '0);
		wait_quiet("host read after remote write");
		finish_test("remote byte write", mark);

		// Test 4, remote read of a host-written word
		mark = errors;
		a = 10'h2A5;
		host_access(1'b1, a, 4'hF, $urandom);
		send_packet(MY_ID, 4'd9, OP_READ, a, 4'hF, '0);
		wait_quiet("read reply");
		finish_test("remote read reply", mark);

		// Test 5, ring output stalled while traffic keeps coming
		mark = errors;
		stretch = $urandom_range(20, 60);
		ring_out_ready = 1'b0;
		fork
			begin
				repeat (stretch) @(posedge clk);
				#DRV ring_out_ready = 1'b1;
			end
			begin
				send_packet(MY_ID, 4'd12, OP_READ, 10'h123, 4'hF, '0);
				send_packet(MY_ID, 4'd12, OP_WRITE, 10'h300, 4'hF, $urandom);
				send_packet(MY_ID, 4'd12, OP_WRITE, 10'h301, 4'hF, $urandom);
				repeat (5) send_foreign();
			end
		join
		wait_quiet("traffic after back-pressure");
		finish_test("back-pressure", mark);

		// Test 6, host reads compete with queued remote requests
		mark = errors;
		for (int i = 0; i < 8; i++) host_access(1'b1, RAM_AW'(10'h40 + i), 4'hF, $urandom);
		for (int i = 0; i < 4; i++) host_access(1'b1, RAM_AW'(10'h80 + i), 4'hF, $urandom);
		fork
			for (int i = 0; i < 8; i++) host_access(1'b0, RAM_AW'(10'h40 + i), '0, '0);
			begin
				for (int i = 0; i < 4; i++) begin
					send_packet(MY_ID, 4'd7, OP_WRITE, RAM_AW'(10'h80 + i),
						SEL_W'($urandom_range(1, 15)), $urandom);
				end
				send_packet(MY_ID, 4'd7, OP_READ, 10'h041, 4'hF, '0);
				send_packet(MY_ID, 4'd7, OP_READ, 10'h046, 4'hF, '0);
			end
		join
		wait_quiet("competing accesses");
		for (int i = 0; i < 4; i++) host_access(1'b0, RAM_AW'(10'h80 + i), '0, '0);
		wait_quiet("host read back");
		finish_test("host read timing", mark);

		$display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_passed, tests_run - tests_passed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
hw/ring_pkg.sv
hw/mem_pkg.sv
hw/req_fifo.sv
hw/node_ram.sv
hw/node_arbiter.sv
hw/ring_nic.sv
hw/ring_node.sv
tb/ring_node_sva.sv
tb/tb_ring_node.sv

//--- Makefile
# Verilator build and run for the ring node testbench

VERILATOR  ?= verilator
TOP        ?= tb_ring_node
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, so a crashed or stopped run also fails
run: build
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
